// ==== verilog/cache_defines.svh ====
`ifndef CACHE_DEFINES_SVH
`define CACHE_DEFINES_SVH

//////////////////////////////////////////////////
// Cache geometry
//////////////////////////////////////////////////
`define CACHE_LINES 64
`define LINE_WORDS 8
`define TAG_W 21
`define INDEX_W 6
`define OFFSET_W 3

//////////////////////////////////////////////////
// Main memory geometry
//////////////////////////////////////////////////
`define MEM_ADDR_W 13
`define MEM_WORDS 8192

`endif

// ==== verilog/cache_addr_pkg.sv ====
`include "cache_defines.svh"

package cache_addr_pkg;

    // Data word and processor byte address
    typedef logic [31:0] word_t;
    typedef logic [31:0] cpu_addr_t;

    // Fields of a byte address
    typedef logic [`TAG_W-1:0] tag_t;
    typedef logic [`INDEX_W-1:0] index_t;
    typedef logic [`OFFSET_W-1:0] offset_t;

    // Data store address, index above offset
    typedef logic [`INDEX_W+`OFFSET_W-1:0] data_addr_t;

    // Main memory word address
    // low tag bits, then index, then offset
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

endpackage

// ==== verilog/cache_ctrl_pkg.sv ====
`include "cache_defines.svh"

package cache_ctrl_pkg;

    // Controller states
    typedef enum logic [1:0] {IDLE, COMPARE, FILL, WBACK} cache_state_t;

    // Tag entry is {dirty, valid, tag}
    typedef logic [`TAG_W+1:0] tag_entry_t;

endpackage

// ==== verilog/main_mem.sv ====
`timescale 1ns/1ps
`include "cache_defines.svh"

module main_mem
    import cache_addr_pkg::*;
(
    input  logic      clk,
    input  logic      a_we,
    input  mem_addr_t a_addr,
    input  word_t     a_din,
    output word_t     a_dout,
    input  logic      b_we,
    input  mem_addr_t b_addr,
    input  word_t     b_din,
    output word_t     b_dout
);

    word_t mem [`MEM_WORDS];

    // Registered read, a write shows its own data on the same port
    always_ff @(posedge clk) begin
        if (a_we) begin
            mem[a_addr] <= a_din;
            a_dout <= a_din;
        end else begin
            a_dout <= mem[a_addr];
        end
        if (b_we) begin
            mem[b_addr] <= b_din;
            b_dout <= b_din;
        end else begin
            b_dout <= mem[b_addr];
        end
    end

    // Port B user must keep off the line the cache is moving
    a_b_write_clash: assert property (@(posedge clk) !(a_we && b_we && (a_addr == b_addr)))
        else $error("main_mem: both ports write word %0h", a_addr);

endmodule

// ==== verilog/cache_arrays.sv ====
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_arrays
    import cache_addr_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Tag store
    input  index_t     tag_index,
    input  logic       tag_we,
    input  tag_entry_t tag_din,
    output tag_entry_t tag_dout,

    // Data store
    input  data_addr_t data_addr,
    input  logic       data_we,
    input  word_t      data_din,
    output word_t      data_dout
);

    //////////////////////////////////////////////////
    // Tag store
    //////////////////////////////////////////////////

    // Status bits kept as flat vectors so reset clears them in one cycle
    logic [`CACHE_LINES-1:0] valid_bits;
    logic [`CACHE_LINES-1:0] dirty_bits;
    tag_t                    tag_mem [`CACHE_LINES];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (tag_we) begin
            dirty_bits[tag_index] <= tag_din[`TAG_W+1];
            valid_bits[tag_index] <= tag_din[`TAG_W];
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[tag_index] <= tag_din[`TAG_W-1:0];
        end
    end

    assign tag_dout = {dirty_bits[tag_index], valid_bits[tag_index], tag_mem[tag_index]};

    //////////////////////////////////////////////////
    // Data store
    //////////////////////////////////////////////////
    word_t data_mem [`CACHE_LINES*`LINE_WORDS];

    always_ff @(posedge clk) begin
        if (data_we) begin
            data_mem[data_addr] <= data_din;
        end
    end

    // Combinational read
    assign data_dout = data_mem[data_addr];

endmodule

// ==== verilog/line_fill.sv ====
`timescale 1ns/1ps
`include "cache_defines.svh"

module line_fill
    import cache_addr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  mem_addr_t line_base,

    // Main memory port A
    output mem_addr_t mem_addr,
    input  word_t     mem_dout,

    // Data store write side
    output offset_t   data_offset,
    output word_t     data_din,
    output logic      data_we,
    output logic      done
);

    localparam offset_t LAST_WORD = offset_t'(`LINE_WORDS - 1);

    logic    busy;
    offset_t word_cnt;
    logic    wr_valid;
    offset_t wr_offset;

    // Address phase
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            word_cnt <= '0;
        end else if (start) begin
            busy <= 1'b1;
            word_cnt <= '0;
        end else if (busy) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == LAST_WORD) begin
                busy <= 1'b0;
            end
        end
    end

    // Memory data lands one cycle after its address
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= busy;
        end
    end

    always_ff @(posedge clk) begin
        wr_offset <= word_cnt;
    end

    assign mem_addr    = {line_base[`MEM_ADDR_W-1:`OFFSET_W], word_cnt};
    assign data_offset = wr_offset;
    assign data_din    = mem_dout;
    assign data_we     = wr_valid;
    assign done        = wr_valid && (wr_offset == LAST_WORD);

    // A new fill may only start once the previous one has written its last word
    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy && !wr_valid)
        else $error("line_fill: start while busy");

endmodule

// ==== verilog/line_writeback.sv ====
`timescale 1ns/1ps
`include "cache_defines.svh"

module line_writeback
    import cache_addr_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  mem_addr_t line_base,

    // Data store read side
    output offset_t   data_offset,
    input  word_t     data_dout,

    // Main memory port A
    output mem_addr_t mem_addr,
    output word_t     mem_din,
    output logic      mem_we,
    output logic      done
);

    localparam offset_t LAST_WORD = offset_t'(`LINE_WORDS - 1);

    logic    busy;
    offset_t word_cnt;

    //////////////////////////////////////////////////
    // Word counter
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            word_cnt <= '0;
        end else if (start) begin
            busy <= 1'b1;
            word_cnt <= '0;
        end else if (busy) begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == LAST_WORD) begin
                busy <= 1'b0;
            end
        end
    end

    // Data store read is combinational, so each word goes out the same cycle
    assign data_offset = word_cnt;
    assign mem_addr    = {line_base[`MEM_ADDR_W-1:`OFFSET_W], word_cnt};
    assign mem_din     = data_dout;
    assign mem_we      = busy;

    // Last word
    assign done = busy && (word_cnt == LAST_WORD);

    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> !busy)
        else $error("line_writeback: start while busy");

endmodule

// ==== verilog/simple_cache.sv ====
`timescale 1ns/1ps
`include "cache_defines.svh"

module simple_cache
    import cache_addr_pkg::*;
    import cache_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Processor side
    input  logic      read_en,
    input  logic      write_en,
    input  cpu_addr_t addr,
    input  word_t     write_data,
    output word_t     read_data,
    output logic      stall,

    // Memory port B straight to the pins
    input  logic      mem_b_we,
    input  mem_addr_t mem_b_addr,
    input  word_t     mem_b_din,
    output word_t     mem_b_dout
);

    // Tag bits that reach main memory
    localparam int MEM_TAG_W = `MEM_ADDR_W - `INDEX_W - `OFFSET_W;

    cache_state_t state;
    cache_state_t next_state;

    tag_t       cpu_tag;
    index_t     cpu_index;
    offset_t    cpu_offset;

    tag_entry_t tag_dout;
    tag_entry_t tag_din;
    logic       tag_we;
    tag_t       stored_tag;
    logic       entry_valid;
    logic       entry_dirty;
    logic       request;
    logic       hit;
    logic       write_hit;
    logic       victim_dirty;

    data_addr_t data_addr;
    word_t      data_din;
    logic       data_we;
    word_t      data_dout;

    mem_addr_t  mem_a_addr;
    logic       mem_a_we;
    word_t      mem_a_dout;

    logic       fill_start;
    logic       fill_done;
    mem_addr_t  fill_base;
    mem_addr_t  fill_mem_addr;
    offset_t    fill_offset;
    word_t      fill_din;
    logic       fill_we;

    logic       wb_start;
    logic       wb_done;
    mem_addr_t  wb_base;
    mem_addr_t  wb_mem_addr;
    offset_t    wb_offset;
    word_t      wb_mem_din;
    logic       wb_we;

    //////////////////////////////////////////////////
    // Address split and hit detection
    //////////////////////////////////////////////////
    assign cpu_tag    = addr[31 -: `TAG_W];
    assign cpu_index  = addr[2+`OFFSET_W +: `INDEX_W];
    assign cpu_offset = addr[2 +: `OFFSET_W];

    assign stored_tag  = tag_dout[`TAG_W-1:0];
    assign entry_valid = tag_dout[`TAG_W];
    assign entry_dirty = tag_dout[`TAG_W+1];

    assign request      = read_en || write_en;
    assign hit          = entry_valid && (stored_tag == cpu_tag);
    assign write_hit    = (state == IDLE) && write_en && hit;
    assign victim_dirty = entry_valid && entry_dirty;

    // Only a hit presented in IDLE lets the processor go
    assign stall = request && !((state == IDLE) && hit);

    //////////////////////////////////////////////////
    // Controller
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (request && !hit) begin
                    next_state = COMPARE;
                end
            end
            COMPARE: begin
                next_state = victim_dirty ? WBACK : FILL;
            end
            WBACK: begin
                if (wb_done) begin
                    next_state = FILL;
                end
            end
            FILL: begin
                if (fill_done) begin
                    next_state = IDLE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    // One cycle start pulse per engine
    always_ff @(posedge clk) begin
        if (rst) begin
            fill_start <= 1'b0;
            wb_start <= 1'b0;
        end else begin
            fill_start <= ((state == COMPARE) && !victim_dirty) || ((state == WBACK) && wb_done);
            wb_start <= (state == COMPARE) && victim_dirty;
        end
    end

    // Fill base comes from the new tag and writeback base from the victim's tag
    assign fill_base = {cpu_tag[MEM_TAG_W-1:0], cpu_index, {`OFFSET_W{1'b0}}};
    assign wb_base   = {stored_tag[MEM_TAG_W-1:0], cpu_index, {`OFFSET_W{1'b0}}};

    //////////////////////////////////////////////////
    // Tag and data store steering
    //////////////////////////////////////////////////
    // New line enters valid and clean and a write hit marks it dirty
    assign tag_we  = fill_done || write_hit;
    assign tag_din = {!fill_done, 1'b1, cpu_tag};

    always_comb begin
        case (state)
            FILL: begin
                data_addr = {cpu_index, fill_offset};
                data_din  = fill_din;
                data_we   = fill_we;
            end
            WBACK: begin
                data_addr = {cpu_index, wb_offset};
                data_din  = write_data;
                data_we   = 1'b0;
            end
            default: begin
                data_addr = {cpu_index, cpu_offset};
                data_din  = write_data;
                data_we   = write_hit;
            end
        endcase
    end

    assign read_data = data_dout;

    // Port A belongs to the writeback engine only in WBACK
    assign mem_a_addr = (state == WBACK) ? wb_mem_addr : fill_mem_addr;
    assign mem_a_we   = (state == WBACK) && wb_we;

    //////////////////////////////////////////////////
    // Submodules
    //////////////////////////////////////////////////
    main_mem main_mem_i (
        .clk    (clk),
        .a_we   (mem_a_we),
        .a_addr (mem_a_addr),
        .a_din  (wb_mem_din),
        .a_dout (mem_a_dout),
        .b_we   (mem_b_we),
        .b_addr (mem_b_addr),
        .b_din  (mem_b_din),
        .b_dout (mem_b_dout)
    );

    cache_arrays cache_arrays_i (
        .clk       (clk),
        .rst       (rst),
        .tag_index (cpu_index),
        .tag_we    (tag_we),
        .tag_din   (tag_din),
        .tag_dout  (tag_dout),
        .data_addr (data_addr),
        .data_we   (data_we),
        .data_din  (data_din),
        .data_dout (data_dout)
    );

    line_fill line_fill_i (
        .clk         (clk),
        .rst         (rst),
        .start       (fill_start),
        .line_base   (fill_base),
        .mem_addr    (fill_mem_addr),
        .mem_dout    (mem_a_dout),
        .data_offset (fill_offset),
        .data_din    (fill_din),
        .data_we     (fill_we),
        .done        (fill_done)
    );

    line_writeback line_writeback_i (
        .clk         (clk),
        .rst         (rst),
        .start       (wb_start),
        .line_base   (wb_base),
        .data_offset (wb_offset),
        .data_dout   (data_dout),
        .mem_addr    (wb_mem_addr),
        .mem_din     (wb_mem_din),
        .mem_we      (wb_we),
        .done        (wb_done)
    );

    // Each start lands in the first cycle of its own state, so the two never overlap
    starts_exclusive: assert property (@(posedge clk) disable iff (rst)
        (!fill_start || (state == FILL)) && (!wb_start || (state == WBACK)))
        else $error("simple_cache: engine start outside its own state");

endmodule

// ==== verif/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_defines.svh"

module cache_tb
    import cache_addr_pkg::*;
();

    localparam int HALF_PERIOD   = 4;
    localparam int SETTLE        = 1;
    localparam int RESET_CYCLES  = 5;
    localparam int PRELOAD_WORDS = 1024;
    localparam int ROW_CYCLES    = 30;

    typedef enum logic [1:0] {CPU_READ, CPU_WRITE, PORT_B_READ, PORT_B_WRITE} op_t;

    logic      clk;
    logic      rst;
    logic      read_en;
    logic      write_en;
    cpu_addr_t addr;
    word_t     write_data;
    word_t     read_data;
    logic      stall;
    logic      mem_b_we;
    mem_addr_t mem_b_addr;
    word_t     mem_b_din;
    word_t     mem_b_dout;

    // One entry per table row in each queue
    string     row_name [$];
    op_t       row_op [$];
    cpu_addr_t row_addr [$];
    word_t     row_data [$];
    logic      row_stall [$];

    // Memory as the processor sees it
    word_t       ref_mem [`MEM_WORDS];
    logic [31:0] lfsr_state;
    int          cycle_count = 0;
    int          timeout_limit;

    simple_cache dut_i (
        .clk        (clk),
        .rst        (rst),
        .read_en    (read_en),
        .write_en   (write_en),
        .addr       (addr),
        .write_data (write_data),
        .read_data  (read_data),
        .stall      (stall),
        .mem_b_we   (mem_b_we),
        .mem_b_addr (mem_b_addr),
        .mem_b_din  (mem_b_din),
        .mem_b_dout (mem_b_dout)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Random data
    //////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One step per bit taken
    task automatic next_random_word(output word_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    //////////////////////////////////////////////////
    // Test table
    //////////////////////////////////////////////////
    task automatic add_row(input string name, input op_t op, input cpu_addr_t a,
                           input word_t data, input logic exp_stall);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(a);
        row_data.push_back(data);
        row_stall.push_back(exp_stall);
    endtask

    // Line 5 uses words 40..47 and 552..559, line 9 uses 72 and 584,
    // line 20 uses 160..167 and 672..679
    task automatic build_table();
        add_row("rd_miss_first",      CPU_READ,    32'h0A4, 32'h0,        1'b1);
        add_row("rd_hit_same_line",   CPU_READ,    32'h0B8, 32'h0,        1'b0);
        add_row("wr_hit",             CPU_WRITE,   32'h0A8, 32'hDEADBEEF, 1'b0);
        add_row("rd_after_wr",        CPU_READ,    32'h0A8, 32'h0,        1'b0);
        add_row("rd_evict_dirty",     CPU_READ,    32'h8A8, 32'h0,        1'b1);
        add_row("portb_written_back", PORT_B_READ, 32'h0A8, 32'h0,        1'b0);
        add_row("portb_neighbor",     PORT_B_READ, 32'h0A4, 32'h0,        1'b0);
        add_row("rd_clean_line",      CPU_READ,    32'h120, 32'h0,        1'b1);
        // Memory under the clean line now differs from the cached copy
        add_row("portb_wr_clean",     PORT_B_WRITE, 32'h120, 32'h5A5A0F0F, 1'b0);
        add_row("rd_evict_clean",     CPU_READ,    32'h920, 32'h0,        1'b1);
        add_row("portb_clean_old",    PORT_B_READ, 32'h120, 32'h0,        1'b0);
        add_row("wr_miss",            CPU_WRITE,   32'h284, 32'h12345678, 1'b1);
        add_row("rd_after_wr_miss",   CPU_READ,    32'h284, 32'h0,        1'b0);
        add_row("rd_neighbor_lo",     CPU_READ,    32'h280, 32'h0,        1'b0);
        add_row("rd_neighbor_hi",     CPU_READ,    32'h29C, 32'h0,        1'b0);
        add_row("rd_back_first_line", CPU_READ,    32'h0A8, 32'h0,        1'b1);
        add_row("wr_miss_evict",      CPU_WRITE,   32'hA80, 32'hCAFEF00D, 1'b1);
        add_row("portb_wr_miss_line", PORT_B_READ, 32'h284, 32'h0,        1'b0);
        add_row("portb_line_lo",      PORT_B_READ, 32'h280, 32'h0,        1'b0);
        add_row("rd_after_evict_wr",  CPU_READ,    32'hA80, 32'h0,        1'b0);
        add_row("rd_evict_neighbor",  CPU_READ,    32'hA84, 32'h0,        1'b0);
    endtask

    //////////////////////////////////////////////////
    // Checking
    //////////////////////////////////////////////////
    task automatic end_with_failure();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        assert (actual == expected) else begin
            $display("Error: %s expected %08h actual %08h", name, expected, actual);
            end_with_failure();
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_limit);
            end_with_failure();
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    task automatic preload_memory();
        word_t w;
        for (int i = 0; i < PRELOAD_WORDS; i++) begin
            next_random_word(w);
            @(negedge clk);
            mem_b_we   = 1'b1;
            mem_b_addr = mem_addr_t'(i);
            mem_b_din  = w;
            ref_mem[i] = w;
        end
        @(negedge clk);
        mem_b_we = 1'b0;
    endtask

    task automatic apply_row(input int r);
        cpu_addr_t a;
        mem_addr_t word_addr;
        a = row_addr[r];
        // Word address in memory is tag low bits, index, offset
        word_addr = a[`MEM_ADDR_W+1:2];
        @(negedge clk);
        read_en  = 1'b0;
        write_en = 1'b0;
        case (row_op[r])
            CPU_READ, CPU_WRITE: begin
                read_en    = (row_op[r] == CPU_READ);
                write_en   = (row_op[r] == CPU_WRITE);
                addr       = a;
                write_data = row_data[r];
                #SETTLE;
                check_value({row_name[r], " stall"}, word_t'(row_stall[r]), word_t'(stall));
                while (stall) begin
                    @(negedge clk);
                    #SETTLE;
                end
                if (write_en) begin
                    ref_mem[word_addr] = row_data[r];
                end else begin
                    check_value(row_name[r], ref_mem[word_addr], read_data);
                end
                // Access completes here
                @(posedge clk);
            end
            PORT_B_READ: begin
                mem_b_addr = word_addr;
                @(posedge clk);
                @(negedge clk);
                check_value(row_name[r], ref_mem[word_addr], mem_b_dout);
            end
            PORT_B_WRITE: begin
                mem_b_we   = 1'b1;
                mem_b_addr = word_addr;
                mem_b_din  = row_data[r];
                ref_mem[word_addr] = row_data[r];
                @(negedge clk);
                mem_b_we = 1'b0;
            end
        endcase
    endtask

    initial begin
        build_table();
        timeout_limit = RESET_CYCLES + PRELOAD_WORDS + ROW_CYCLES * row_name.size() + 10;
        lfsr_state = 32'd79344;
        rst        = 1'b1;
        read_en    = 1'b0;
        write_en   = 1'b0;
        addr       = '0;
        write_data = '0;
        mem_b_we   = 1'b0;
        mem_b_addr = '0;
        mem_b_din  = '0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        #SETTLE;
        check_value("stall_after_reset", 32'd0, word_t'(stall));
        preload_memory();
        for (int r = 0; r < row_name.size(); r++) begin
            apply_row(r);
        end
        @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/cache_addr_pkg.sv
verilog/cache_ctrl_pkg.sv
verilog/main_mem.sv
verilog/cache_arrays.sv
verilog/line_fill.sv
verilog/line_writeback.sv
verilog/simple_cache.sv
verif/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the cache testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module cache_tb \
    -Mdir "$BUILD_DIR" -o cache_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/cache_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
